//--- logic/condCheck.sv
// Condition code check
`timescale 1ns/1ps

module condCheck import microOpPkg::*; (
	input  instrWord_u instr,
	input  flags_t     flags,
	output logic       condPass
);
	logic nEqV;

	assign nEqV = (flags.n == flags.v);

	always_comb begin
		case (instr.dpView.cond)
			4'h0: condPass = flags.z;                // EQ
			4'h1: condPass = !flags.z;               // NE
			4'h2: condPass = flags.c;                // CS
			4'h3: condPass = !flags.c;               // CC
			4'h4: condPass = flags.n;                // MI
			4'h5: condPass = !flags.n;               // PL
			4'h6: condPass = flags.v;                // VS
			4'h7: condPass = !flags.v;               // VC
			4'h8: condPass = flags.c && !flags.z;    // HI
			4'h9: condPass = !flags.c || flags.z;    // LS
			4'hA: condPass = nEqV;                   // GE
			4'hB: condPass = !nEqV;                  // LT
			4'hC: condPass = !flags.z && nEqV;       // GT
			4'hD: condPass = flags.z || !nEqV;       // LE
			4'hE: condPass = 1'b1;                   // AL
			default: condPass = 1'b0;                // Never
		endcase
	end
endmodule

//--- logic/microOpPkg.sv
// Micro-op expander types
package microOpPkg;
	`include "microOp_settings.svh"

	// Data-processing decode of the instruction word
	typedef struct packed {
		logic [3:0]  cond;     // Condition field
		logic [2:0]  cls;      // Bits 27:25
		logic [3:0]  opcode;   // Bits 24:21
		logic        s;        // Flag update
		logic [3:0]  rn;
		logic [3:0]  rd;
		logic [11:0] operand;  // Shifter operand or offset
	} dpView_t;

	// Block transfer decode of the same word
	typedef struct packed {
		logic [3:0]            cond;
		logic [2:0]            cls;
		logic                  p;        // Before/after
		logic                  u;        // Up/down
		logic                  b;        // Byte, also S bit on block transfers
		logic                  w;        // Base writeback
		logic                  l;        // Load when set
		logic [3:0]            rn;       // Base register
		logic [`REG_COUNT-1:0] regList;
	} blockView_t;

	typedef union packed {
		dpView_t    dpView;
		blockView_t blockView;
	} instrWord_u;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	// Steering controls for the datapath
	typedef struct packed {
		logic       instrMux;       // Select micro-op word over fetched word
		logic       noFlagUpdate;
		logic       keepV;          // Multiply keeps V
		logic       prevRsr;        // Second half of a split op
		logic       ldmStmForward;  // Forward Rz address in block transfers
		logic [3:0] regFileRz;      // Mux select, then Rz on WA3, RA2, RA1
	} uOpCtrl_t;

	typedef struct packed {
		logic [4:0]  spare;
		logic [3:0]  nextReg;      // Lowest register still to move
		logic [11:0] startOffset;  // Byte offset of first access
		logic        addUp;
		logic        lastReg;      // One register left
		logic        noRegsLeft;
	} regInfo_t;

	typedef enum logic [2:0] {
		ready, rsrOp, macAdd, blBranch, blockLoad, blockStore
	} seqState_t;

	typedef enum logic [3:0] {
		passThru, rsrShift, rsrApply, macMul, macAccum, blLink, blJump,
		blockFirst, blockNext, blockNextWb, blockNop
	} stepKind_t;
endpackage

//--- logic/microOpTop.sv
// Micro-op expander top level
`timescale 1ns/1ps

module microOpTop import microOpPkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  instrWord_u instr,     // Instruction in Decode
	input  logic       hold,      // Pipeline stall level
	input  flags_t     flags,
	output instrWord_u uOpInstr,
	output uOpCtrl_t   uOpCtrl,
	output logic       uOpStall   // Stalls fetch mid-sequence
);
	stepKind_t step;
	regInfo_t  regInfo;
	logic      listLoad;
	logic      condPass;

	uOpSequencer sequencer (
		.clk      (clk),
		.reset    (reset),
		.hold     (hold),
		.instr    (instr),
		.condPass (condPass),
		.regInfo  (regInfo),
		.step     (step),
		.listLoad (listLoad),
		.uOpStall (uOpStall)
	);

	regListCounter listCounter (
		.clk      (clk),
		.reset    (reset),
		.hold     (hold),
		.listLoad (listLoad),
		.instr    (instr),
		.regInfo  (regInfo)
	);

	condCheck cond (
		.instr    (instr),
		.flags    (flags),
		.condPass (condPass)
	);

	uOpComposer composer (
		.instr    (instr),
		.step     (step),
		.regInfo  (regInfo),
		.uOpInstr (uOpInstr),
		.uOpCtrl  (uOpCtrl)
	);
endmodule

//--- logic/microOp_settings.svh
// Micro-op expander constants
`ifndef MICROOP_SETTINGS_SVH
`define MICROOP_SETTINGS_SVH

`define WORD_W      32      // Instruction width
`define REG_COUNT   16      // Architectural registers
`define WORD_BYTES  4       // Bytes per transfer in a block sequence

`define RZ_CODE     4'd15   // Scratch register under the Rz selects
`define LINK_REG    4'd14   // Link register

`define OP_MOV      4'd13   // Data-processing opcodes
`define OP_ADD      4'd4

`define CLS_DP_REG  3'b000  // Bits 27:25 instruction classes
`define CLS_DP_IMM  3'b001
`define CLS_LS_IMM  3'b010
`define CLS_LS_REG  3'b011
`define CLS_BLOCK   3'b100

`endif

//--- logic/regListCounter.sv
// Block transfer register tracker
`timescale 1ns/1ps
`include "microOp_settings.svh"

module regListCounter import microOpPkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       hold,
	input  logic       listLoad,
	input  instrWord_u instr,
	output regInfo_t   regInfo
);
	logic [`REG_COUNT-1:0] listNow;   // Registers not yet transferred
	logic [`REG_COUNT-1:0] srcList;
	logic [`REG_COUNT-1:0] listNext;
	logic [4:0]            regCount;
	logic [11:0]           countBytes;
	logic [3:0]            lowReg;

	assign srcList = listLoad ? instr.blockView.regList : listNow;
	assign regCount = 5'($countones(srcList));
	assign countBytes = 12'(regCount) * 12'(`WORD_BYTES);

	// Lowest set bit, scanning down so the last hit wins
	always_comb begin
		lowReg = 4'd0;
		for (int i = `REG_COUNT - 1; i >= 0; i--) begin
			if (srcList[i]) begin
				lowReg = 4'(i);
			end
		end
	end

	always_comb begin
		listNext = srcList;
		listNext[lowReg] = 1'b0;  // Retire this cycle's register
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			listNow <= '0;
		end else if (!hold) begin
			listNow <= listNext;
		end
	end

	always_comb begin
		regInfo = '0;
		regInfo.nextReg = lowReg;
		regInfo.lastReg = (regCount == 5'd1);
		regInfo.noRegsLeft = (regCount == 5'd0);
		case ({instr.blockView.p, instr.blockView.u})
			2'b00: begin  // Decrement after
				regInfo.startOffset = countBytes - 12'(`WORD_BYTES);
				regInfo.addUp = 1'b0;
			end
			2'b01: begin  // Increment after
				regInfo.startOffset = 12'd0;
				regInfo.addUp = 1'b1;
			end
			2'b10: begin  // Decrement before
				regInfo.startOffset = countBytes;
				regInfo.addUp = 1'b0;
			end
			default: begin  // Increment before
				regInfo.startOffset = 12'(`WORD_BYTES);
				regInfo.addUp = 1'b1;
			end
		endcase
	end
endmodule

//--- logic/uOpComposer.sv
// Micro-op word and control builder
`timescale 1ns/1ps
`include "microOp_settings.svh"

module uOpComposer import microOpPkg::*; (
	input  instrWord_u instr,
	input  stepKind_t  step,
	input  regInfo_t   regInfo,
	output instrWord_u uOpInstr,
	output uOpCtrl_t   uOpCtrl
);
	logic isLoad;

	assign isLoad = instr.blockView.l;

	always_comb begin
		uOpInstr = instr;  // Unlisted fields follow the instruction
		uOpCtrl = '0;
		case (step)
			rsrShift: begin  // MOV Rz, Rm shifted by Rs
				uOpInstr.dpView.opcode = `OP_MOV;
				uOpInstr.dpView.s = 1'b0;
				uOpInstr.dpView.rn = 4'd0;
				uOpInstr.dpView.rd = `RZ_CODE;
				uOpCtrl.instrMux = 1'b1;
				uOpCtrl.noFlagUpdate = 1'b1;
				uOpCtrl.regFileRz = 4'b1100;
			end
			rsrApply: begin  // Original op on unshifted Rz
				uOpInstr.dpView.operand = {8'd0, `RZ_CODE};
				uOpCtrl.instrMux = 1'b1;
				uOpCtrl.prevRsr = 1'b1;
				uOpCtrl.regFileRz = 4'b0010;
			end
			macMul: begin
				uOpInstr.dpView.opcode[0] = 1'b0;  // MLA becomes MUL
				uOpInstr.dpView.rn = `RZ_CODE;     // Product lands in Rz
				uOpInstr.dpView.rd = 4'd0;
				uOpCtrl.instrMux = 1'b1;
				uOpCtrl.keepV = 1'b1;
				uOpCtrl.regFileRz = 4'b1100;
			end
			macAccum: begin  // Rd = Rz + Rn
				uOpInstr.dpView.cls = `CLS_DP_REG;
				uOpInstr.dpView.opcode = `OP_ADD;
				uOpInstr.dpView.s = instr.dpView.s;
				uOpInstr.dpView.rn = `RZ_CODE;
				uOpInstr.dpView.rd = instr.dpView.rn;   // MLA destination sits in 19:16
				uOpInstr.dpView.operand = {8'd0, instr.dpView.rd};  // Accumulator
				uOpCtrl.instrMux = 1'b1;
				uOpCtrl.noFlagUpdate = 1'b1;
				uOpCtrl.prevRsr = 1'b1;
				uOpCtrl.regFileRz = 4'b0001;
			end
			blLink: begin  // MOV LR, PC
				uOpInstr.dpView.cls = `CLS_DP_REG;
				uOpInstr.dpView.opcode = `OP_MOV;
				uOpInstr.dpView.s = 1'b0;
				uOpInstr.dpView.rn = 4'd0;
				uOpInstr.dpView.rd = `LINK_REG;
				uOpInstr.dpView.operand = 12'd15;
				uOpCtrl.instrMux = 1'b1;
			end
			blJump: begin
				uOpInstr.dpView.opcode[3] = 1'b0;  // Link bit off, plain B
				uOpCtrl.instrMux = 1'b1;
			end
			blockFirst: begin  // Single transfer off the base
				uOpInstr.blockView.cls = `CLS_LS_IMM;
				uOpInstr.blockView.p = 1'b1;
				uOpInstr.blockView.u = regInfo.addUp;
				uOpInstr.blockView.b = 1'b0;
				uOpInstr.blockView.w = 1'b0;
				uOpInstr.blockView.regList = {regInfo.nextReg, regInfo.startOffset};
				uOpCtrl.instrMux = 1'b1;
				uOpCtrl.noFlagUpdate = 1'b1;
			end
			blockNext, blockNextWb: begin  // Next word at Rz + 4
				uOpInstr.blockView.cls = isLoad ? `CLS_LS_REG : `CLS_LS_IMM;
				uOpInstr.blockView.p = 1'b1;
				uOpInstr.blockView.u = 1'b1;
				uOpInstr.blockView.b = 1'b0;
				uOpInstr.blockView.w = (step == blockNextWb);
				uOpInstr.blockView.rn = `RZ_CODE;
				uOpInstr.blockView.regList = {regInfo.nextReg, 12'd15};
				uOpCtrl.instrMux = 1'b1;
				uOpCtrl.noFlagUpdate = 1'b1;
				uOpCtrl.ldmStmForward = 1'b1;
				uOpCtrl.regFileRz = isLoad ? 4'b0001 : 4'b0000;
			end
			blockNop: begin  // ADD R0, R0, #0 with flags untouched
				uOpInstr.dpView.cls = `CLS_DP_IMM;
				uOpInstr.dpView.opcode = `OP_ADD;
				uOpInstr.dpView.s = 1'b0;
				uOpInstr.dpView.rn = 4'd0;
				uOpInstr.dpView.rd = 4'd0;
				uOpInstr.dpView.operand = 12'd0;
				uOpCtrl.instrMux = 1'b1;
				uOpCtrl.noFlagUpdate = 1'b1;
			end
			default: begin
				uOpInstr = instr;  // Pass-through
			end
		endcase
	end
endmodule

//--- logic/uOpSequencer.sv
// Micro-op sequence FSM
`timescale 1ns/1ps
`include "microOp_settings.svh"

module uOpSequencer import microOpPkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       hold,
	input  instrWord_u instr,
	input  logic       condPass,
	input  regInfo_t   regInfo,
	output stepKind_t  step,
	output logic       listLoad,  // Counter takes the fresh list
	output logic       uOpStall
);
	seqState_t          state, nextState;
	logic [`WORD_W-1:0] raw;   // Flat view for pattern matching
	logic               isRsr, isShortMac, isBl, isBlock;

	assign raw = instr;

	// Register-shifted register, excluding BX
	assign isRsr = (raw[27:25] == `CLS_DP_REG) && !raw[7] && raw[4] &&
		(raw[27:4] != 24'h12FFF1);
	// MLA only, long forms are left alone
	assign isShortMac = (raw[27:24] == 4'b0000) && !raw[23] && raw[21] &&
		(raw[7:4] == 4'b1001);
	assign isBl = (raw[27:24] == 4'b1011);
	assign isBlock = (raw[27:25] == `CLS_BLOCK) && (|instr.blockView.regList);

	assign listLoad = (state == ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ready;
		end else if (!hold) begin
			state <= nextState;  // Frozen while the pipeline holds
		end
	end

	always_comb begin
		step = passThru;
		nextState = ready;
		uOpStall = 1'b0;
		case (state)
			ready: begin
				if (isRsr) begin
					step = rsrShift;     // Shift into Rz first
					nextState = rsrOp;
					uOpStall = 1'b1;
				end else if (isShortMac) begin
					step = macMul;       // Product into Rz
					nextState = macAdd;
					uOpStall = 1'b1;
				end else if (isBl) begin
					step = blLink;       // Save return address
					nextState = blBranch;
					uOpStall = 1'b1;
				end else if (isBlock) begin
					step = blockFirst;
					if (regInfo.lastReg && !instr.blockView.w) begin
						nextState = ready;   // Single register, nothing follows
					end else begin
						nextState = instr.blockView.l ? blockLoad : blockStore;
						uOpStall = 1'b1;
					end
				end
			end
			rsrOp: begin
				step = rsrApply;
			end
			macAdd: begin
				step = macAccum;
			end
			blBranch: begin
				step = blJump;
			end
			blockLoad, blockStore: begin
				if (!condPass || regInfo.noRegsLeft) begin
					step = blockNop;         // Flush, or trailing writeback slot
				end else if (regInfo.lastReg) begin
					if (instr.blockView.w) begin
						step = blockNextWb;  // Base update, then one nop
						nextState = state;
						uOpStall = 1'b1;
					end else begin
						step = blockNext;
					end
				end else begin
					step = blockNext;
					nextState = state;
					uOpStall = 1'b1;
				end
			end
			default: begin
				step = passThru;
			end
		endcase
	end
endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the micro-op expander testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module microOpTb -f tb.f -o microOpSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/microOpSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "\*\* PASS \*\*" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb.f
+incdir+logic
+incdir+verif
logic/microOpPkg.sv
logic/condCheck.sv
logic/regListCounter.sv
logic/uOpSequencer.sv
logic/uOpComposer.sv
logic/microOpTop.sv
verif/microOpTb.sv

//--- verif/microOpModel.svh
// Micro-op reference model
`ifndef MICROOP_MODEL_SVH
`define MICROOP_MODEL_SVH

typedef struct packed {
	instrWord_u word;
	uOpCtrl_t   ctrl;
	logic       stall;
} expOp_t;

expOp_t      expQ[$];                 // Micro-ops still expected from the DUT
logic [15:0] lfsrState = 16'd34710;

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
function automatic logic [31:0] randBits(input int count);
	logic [31:0] value;
	logic        fb;
	value = '0;
	for (int i = 0; i < count; i++) begin
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		value = {value[30:0], fb};
	end
	return value;
endfunction

// Bits are instrMux, noFlagUpdate, keepV, prevRsr, ldmStmForward
function automatic uOpCtrl_t ctrlOf(input logic [4:0] bits, input logic [3:0] rz);
	uOpCtrl_t c;
	c.instrMux = bits[4];
	c.noFlagUpdate = bits[3];
	c.keepV = bits[2];
	c.prevRsr = bits[1];
	c.ldmStmForward = bits[0];
	c.regFileRz = rz;
	return c;
endfunction

function automatic void pushOp(input logic [31:0] word, input uOpCtrl_t ctrl, input logic stall);
	expOp_t e;
	e.word = word;
	e.ctrl = ctrl;
	e.stall = stall;
	expQ.push_back(e);
endfunction

// ADD R0, R0, #0 under the instruction's condition
function automatic logic [31:0] nopWord(input logic [31:0] w);
	return {w[31:28], 3'b001, `OP_ADD, 1'b0, 4'd0, 4'd0, 12'd0};
endfunction

// Condition pairs share a test, the low bit inverts it
function automatic logic condHolds(input logic [3:0] cond, input flags_t f);
	logic base;
	case (cond[3:1])
		3'd0: base = f.z;
		3'd1: base = f.c;
		3'd2: base = f.n;
		3'd3: base = f.v;
		3'd4: base = f.c && !f.z;
		3'd5: base = (f.n == f.v);
		3'd6: base = !f.z && (f.n == f.v);
		default: base = 1'b1;
	endcase
	if (cond == 4'hF) begin
		return 1'b0;  // Never
	end else begin
		return cond[0] ? !base : base;
	end
endfunction

function automatic void expandInstr(input instrWord_u instr, input flags_t fl);
	logic [31:0] w;
	logic [31:0] op;
	logic [11:0] offs;
	logic        up;
	logic        wb;
	logic        isLd;
	int          n;
	int          low;
	int          left;
	w = instr;
	wb = w[21];
	isLd = w[20];
	n = 0;
	low = -1;
	for (int i = 0; i < `REG_COUNT; i++) begin
		if (w[i]) begin
			n++;
			if (low < 0) low = i;  // Lowest register goes first
		end
	end
	if (w[27:25] == 3'b000 && !w[7] && w[4] && !(w[27:20] == 8'h12 && w[19:4] == 16'hFFF1)) begin
		op = w;
		op[24:21] = `OP_MOV;
		op[20] = 1'b0;
		op[19:16] = 4'd0;
		op[15:12] = `RZ_CODE;
		pushOp(op, ctrlOf(5'b11000, 4'b1100), 1'b1);
		op = w;
		op[11:0] = 12'd15;  // Rz, no shift
		pushOp(op, ctrlOf(5'b10010, 4'b0010), 1'b0);
	end else if (w[27:24] == 4'd0 && !w[23] && w[21] && w[7:4] == 4'b1001) begin
		op = w;
		op[21] = 1'b0;
		op[19:16] = `RZ_CODE;
		op[15:12] = 4'd0;
		pushOp(op, ctrlOf(5'b10100, 4'b1100), 1'b1);
		op = {w[31:28], 3'b000, `OP_ADD, w[20], `RZ_CODE, w[19:16], 8'd0, w[15:12]};
		pushOp(op, ctrlOf(5'b11010, 4'b0001), 1'b0);
	end else if (w[27:24] == 4'b1011) begin
		op = {w[31:28], 3'b000, `OP_MOV, 1'b0, 4'd0, `LINK_REG, 12'd15};
		pushOp(op, ctrlOf(5'b10000, 4'b0000), 1'b1);
		op = w;
		op[24] = 1'b0;
		pushOp(op, ctrlOf(5'b10000, 4'b0000), 1'b0);
	end else if (w[27:25] == 3'b100 && n > 0) begin
		case ({w[24], w[23]})
			2'b00: begin offs = 12'((n - 1) * `WORD_BYTES); up = 1'b0; end
			2'b01: begin offs = 12'd0; up = 1'b1; end
			2'b10: begin offs = 12'(n * `WORD_BYTES); up = 1'b0; end
			default: begin offs = 12'(`WORD_BYTES); up = 1'b1; end
		endcase
		op = w;
		op[27:21] = {3'b010, 1'b1, up, 2'b00};
		op[15:0] = {4'(low), offs};
		pushOp(op, ctrlOf(5'b11000, 4'b0000), (n > 1) || wb);
		if (!condHolds(w[31:28], fl)) begin
			if ((n > 1) || wb) pushOp(nopWord(w), ctrlOf(5'b11000, 4'b0000), 1'b0);
		end else begin
			left = n - 1;
			for (int i = low + 1; i < `REG_COUNT; i++) begin
				if (w[i]) begin
					left--;
					op = w;
					op[27:25] = isLd ? 3'b011 : 3'b010;
					op[24:21] = {3'b110, wb && (left == 0)};  // Writeback on the last one
					op[19:0] = {`RZ_CODE, 4'(i), 12'd15};
					pushOp(op, ctrlOf(5'b11001, isLd ? 4'b0001 : 4'b0000), (left != 0) || wb);
				end
			end
			if (wb) pushOp(nopWord(w), ctrlOf(5'b11000, 4'b0000), 1'b0);
		end
	end else begin
		pushOp(w, ctrlOf(5'b00000, 4'b0000), 1'b0);  // Pass-through
	end
endfunction

`endif

//--- verif/microOpTb.sv
// Micro-op expander testbench
`timescale 1ns/1ps
`include "microOp_settings.svh"

module microOpTb import microOpPkg::*; ();
	localparam int clkPeriod = 100;
	localparam int resetCycles = 16;
	localparam int numTests = 120;
	localparam int testCycles = resetCycles + numTests * (`REG_COUNT + 2);  // Longest sequence

	logic       clk;
	logic       reset;
	logic       hold;
	instrWord_u instr;
	flags_t     flags;
	instrWord_u uOpInstr;
	uOpCtrl_t   uOpCtrl;
	logic       uOpStall;

	int checkCount = 0;
	int errCount = 0;
	int blockIdx = 0;  // Walks the p, u, w, l combinations

	`include "microOpModel.svh"

	microOpTop u_dut (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.hold     (hold),
		.flags    (flags),
		.uOpInstr (uOpInstr),
		.uOpCtrl  (uOpCtrl),
		.uOpStall (uOpStall)
	);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkWord(input instrWord_u got, input instrWord_u exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: uOpInstr expected %h got %h", $time, exp, got);
		end
	endtask

	task automatic checkCtrl(input uOpCtrl_t got, input uOpCtrl_t exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: uOpCtrl expected %b got %b", $time, exp, got);
		end
	endtask

	task automatic checkStall(input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Fail at %0d ns: uOpStall expected %b got %b", $time, exp, got);
		end
	endtask

	// Under hold the same micro-op is checked again
	always @(posedge clk) begin
		expOp_t front;
		if (!reset && expQ.size() > 0) begin
			front = expQ[0];
			checkWord(uOpInstr, front.word);
			checkCtrl(uOpCtrl, front.ctrl);
			checkStall(uOpStall, front.stall);
			if (!hold) void'(expQ.pop_front());
		end
	end

	function automatic logic pickHold();
		logic [31:0] r;
		r = randBits(2);
		return (r[1:0] == 2'd0);  // One cycle in four
	endfunction

	function automatic string kindName(input int kind);
		case (kind)
			0: return "pass-through";
			1: return "register-shifted op";
			2: return "short multiply-accumulate";
			3: return "branch with link";
			4: return "block transfer";
			5: return "block transfer, condition fails";
			default: return "block transfer, empty list";
		endcase
	endfunction

	function automatic instrWord_u makeInstr(input int kind, input logic [3:0] mode);
		logic [31:0] w;
		logic [31:0] r;
		w = randBits(32);
		case (kind)
			0: w[27:25] = {1'b0, w[26], 1'b1};  // Immediate DP or register load/store
			1: begin
				w[27:25] = 3'b000;
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			2: begin
				w[27:23] = 5'b00000;
				w[21] = 1'b1;
				w[7:4] = 4'b1001;
			end
			3: w[27:24] = 4'b1011;
			4, 5: begin
				w[27:25] = 3'b100;
				{w[24], w[23], w[21], w[20]} = mode;
				r = randBits(2);
				if (r[1:0] == 2'd0) begin
					w[15:0] = 16'd1 << w[3:0];  // Single register
				end else if (r[1:0] == 2'd1) begin
					r = randBits(16);
					w[15:0] = w[15:0] & r[15:0];  // Sparse list
				end
				if (w[15:0] == 16'd0) w[0] = 1'b1;
				if (kind == 4 && w[31:28] == 4'hF) begin
					w[31:28] = 4'hE;  // Never would flush every sequence
				end
				if (kind == 5 && w[31:28] == 4'hE) begin
					w[31:28] = 4'hF;  // Always cannot fail
				end
			end
			default: begin
				w[27:25] = 3'b100;
				w[15:0] = 16'd0;
			end
		endcase
		return instrWord_u'(w);
	endfunction

	task automatic runTest(input int t);
		int          kind;
		int          errsBefore;
		logic [31:0] r;
		instrWord_u  word;
		flags_t      fl;
		kind = (t == 0) ? 0 : t % 7;
		errsBefore = errCount;
		r = randBits(4);
		fl = r[3:0];
		if (kind == 4) blockIdx++;
		word = makeInstr(kind, 4'(blockIdx));
		if (kind == 4 || kind == 5) begin
			// Flags stepped until the condition passes, or fails for the flush test
			for (int k = 0; k < 16; k++) begin
				if (condHolds(word.blockView.cond, fl) != (kind == 4)) begin
					fl = flags_t'(4'(fl) + 4'd1);
				end
			end
		end
		instr = word;
		flags = fl;
		hold = pickHold();
		expandInstr(word, fl);
		@(negedge clk);
		while (expQ.size() != 0) begin
			hold = pickHold();
			@(negedge clk);
		end
		if (errCount == errsBefore) begin
			$display("Test %0d %s %h: ok", t, kindName(kind), word);
		end else begin
			$display("Test %0d %s %h: %0d errors", t, kindName(kind), word, errCount - errsBefore);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		hold = 1'b0;
		instr = '0;
		flags = '0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < numTests; t++) begin
			runTest(t);
		end
		$display("Tests %0d, checks %0d, errors %0d", numTests, checkCount, errCount);
		if (errCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(testCycles * 2 * clkPeriod);
		$display("Timeout: tests did not finish within %0d cycles", testCycles * 2);
		$display("** FAIL **");
		$finish;
	end
endmodule
